//--- isaPkg.sv
// Instruction encoding of the load/store ISA; import it wherever opcodes or word fields are decoded
`default_nettype none

package isaPkg;

	// ====================
	// Field widths
	// ====================

	// Datapath width, which is also the width of an extended immediate
	localparam int XLEN = 32;
	localparam int OPCODE_WIDTH = 7;
	localparam int FUNCT_WIDTH = 3;
	localparam int REG_FIELD_WIDTH = 5;

	// The immediate overlays the rs2 and funct fields and the spare bits above them
	localparam int IMM_WIDTH = 14;
	localparam int IMM_LSB = 17;
	localparam int IMM_UPPER_WIDTH = IMM_WIDTH - FUNCT_WIDTH - REG_FIELD_WIDTH;

	// ====================
	// Funct encodings
	// ====================

	// LOAD with this funct adds rs2 to the address
	localparam logic [FUNCT_WIDTH-1:0] FUNCT_LOAD_INDEXED = 3'd1;
	// BCC with this funct compares rs1 against zero and has no rs2
	localparam logic [FUNCT_WIDTH-1:0] FUNCT_BCC_ZERO = 3'd7;
	// MOV with this funct names r31 itself rather than the banked stack pointer
	localparam logic [FUNCT_WIDTH-1:0] FUNCT_MOV_RAW = 3'd1;

	// ====================
	// Opcodes
	// ====================

	// Any value outside this list is an illegal instruction
	typedef enum logic [OPCODE_WIDTH-1:0] {
		OP_NOP = 7'h00,
		OP_ADD = 7'h01,
		OP_SUB = 7'h02,
		OP_AND = 7'h03,
		OP_OR = 7'h04,
		OP_XOR = 7'h05,
		OP_SHIFT = 7'h06,
		OP_MUL = 7'h07,
		OP_LOAD = 7'h10,
		OP_STORE = 7'h11,
		OP_BCC = 7'h20,
		OP_FLT = 7'h30,
		OP_CSR = 7'h38,
		OP_MOV = 7'h40
	} opcodeE;

	// Instruction word, most significant field first
	typedef struct packed {
		logic immFlag;
		// Bits 30:25 are only meaningful as the top of the immediate
		logic [IMM_UPPER_WIDTH-1:0] immUpper;
		logic [FUNCT_WIDTH-1:0] funct;
		logic [REG_FIELD_WIDTH-1:0] rs2;
		logic [REG_FIELD_WIDTH-1:0] rs1;
		logic [REG_FIELD_WIDTH-1:0] rd;
		opcodeE opcode;
	} instrWordT;

endpackage

`default_nettype wire

//--- decodePkg.sv
// Decode-stage result types; import it where register numbers or decoded records are built
`default_nettype none

package decodePkg;

	// ====================
	// Modes and registers
	// ====================

	// Operating mode, which selects the banked stack pointer
	typedef enum logic [1:0] {
		MODE_USER = 2'd0,
		MODE_SUPER = 2'd1,
		MODE_HYPER = 2'd2,
		MODE_MACHINE = 2'd3
	} opModeE;

	// Architectural register number is a bank on top of a field index
	localparam int BANK_WIDTH = 2;
	localparam int AREG_WIDTH = BANK_WIDTH + isaPkg::REG_FIELD_WIDTH;
	typedef logic [AREG_WIDTH-1:0] aregNoT;

	localparam logic [BANK_WIDTH-1:0] BANK_INT = 2'b00;
	localparam logic [BANK_WIDTH-1:0] BANK_FP = 2'b01;
	localparam logic [BANK_WIDTH-1:0] BANK_SP = 2'b10;

	// First of the four per-mode stack pointers
	localparam aregNoT SP_BANK_BASE = aregNoT'(64);
	// Integer r31 is the stack pointer as the encoding names it
	localparam aregNoT SP_AREG = aregNoT'(31);

	// ====================
	// Pipeline records
	// ====================

	// Output of the instruction latch
	typedef struct packed {
		isaPkg::instrWordT instr;
		opModeE mode;
		logic illegal;
	} fetchedT;

	// Record handed to the next stage
	typedef struct packed {
		aregNoT rd;
		aregNoT rs1;
		aregNoT rs2;
		logic rdZero;
		logic rs2Zero;
		logic hasImm;
		logic [isaPkg::XLEN-1:0] imm;
		logic illegal;
	} decodedT;

endpackage

`default_nettype wire

//--- instrLatch.sv
// Input register of the decode stage; captures a strobed instruction and mode and checks the opcode
`timescale 1ns/1ps
`default_nettype none

module instrLatch (
	input wire logic clk,
	input wire logic rstN,
	input wire logic inStrobe,
	input wire isaPkg::instrWordT inInstr,
	input wire decodePkg::opModeE inMode,
	output decodePkg::fetchedT fetched,
	output logic fetchedValid
);
	import isaPkg::*;

	logic illegalOp;

	// NOP is legal and simply decodes to nothing
	always_comb
	begin
		case (inInstr.opcode)
			OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHIFT, OP_MUL,
			OP_LOAD, OP_STORE, OP_BCC, OP_FLT, OP_CSR, OP_MOV:
				illegalOp = 1'b0;
			default:
				illegalOp = 1'b1;
		endcase
	end

	// Valid follows the strobe by one cycle
	always_ff @(posedge clk)
	begin
		if (!rstN)
			fetchedValid <= 1'b0;
		else
			fetchedValid <= inStrobe;
	end

	// Payload only moves on a strobe and holds otherwise
	always_ff @(posedge clk)
	begin
		if (inStrobe)
		begin
			fetched.instr <= inInstr;
			fetched.mode <= inMode;
			fetched.illegal <= illegalOp;
		end
	end

	// The mode picks a stack pointer downstream, so it must be known when taken
	modeKnown: assert property (@(posedge clk) disable iff (!rstN)
		inStrobe |-> !$isunknown(inMode))
		else $error("instrLatch: mode has unknown bits on inStrobe");

endmodule

`default_nettype wire

//--- decodeImm.sv
// Immediate decoder; flags whether the latched instruction carries an immediate and extends it
`timescale 1ns/1ps
`default_nettype none

module decodeImm (
	input wire decodePkg::fetchedT fetched,
	output logic hasImm,
	output logic [isaPkg::XLEN-1:0] imm
);
	import isaPkg::*;

	logic immCapable;
	logic [IMM_WIDTH-1:0] immField;

	// ====================
	// Opcode class
	// ====================

	// Branches, CSR and FP ops reuse bit 31 for other purposes
	always_comb
	begin
		case (fetched.instr.opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHIFT, OP_MUL,
			OP_LOAD, OP_STORE, OP_MOV:
				immCapable = 1'b1;
			default:
				immCapable = 1'b0;
		endcase
	end

	assign hasImm = fetched.instr.immFlag & immCapable;

	// ====================
	// Extension
	// ====================

	// Raw immediate bits, which overlap funct and rs2
	assign immField = fetched.instr[IMM_LSB +: IMM_WIDTH];

	// Sign extend from the top immediate bit
	// A zero here keeps a stale field from leaking into the record
	assign imm = hasImm ? {{(XLEN - IMM_WIDTH){immField[IMM_WIDTH-1]}}, immField} : '0;

endmodule

`default_nettype wire

//--- decodeRs2.sv
// Second source register decoder; includes the per-mode stack pointer remap for MOV
`timescale 1ns/1ps
`default_nettype none

module decodeRs2 (
	input wire decodePkg::fetchedT fetched,
	input wire logic hasImm,
	output decodePkg::aregNoT rs2,
	output logic rs2Zero
);
	import isaPkg::*;
	import decodePkg::*;

	always_comb
	begin
		// An immediate occupies the rs2 field, so there is no second register
		if (hasImm)
			rs2 = '0;
		else
		begin
			case (fetched.instr.opcode)
				OP_FLT:
					rs2 = {BANK_FP, fetched.instr.rs2};
				// Only the register form of a CSR access reads rs2
				OP_CSR:
					rs2 = (fetched.instr.funct == '0) ? {BANK_INT, fetched.instr.rs2} : '0;
				OP_BCC:
					rs2 = (fetched.instr.funct != FUNCT_BCC_ZERO) ?
						{BANK_INT, fetched.instr.rs2} : '0;
				OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHIFT, OP_MUL:
					rs2 = {BANK_INT, fetched.instr.rs2};
				// A plain load uses only rs1 as the base
				OP_LOAD:
					rs2 = (fetched.instr.funct == FUNCT_LOAD_INDEXED) ?
						{BANK_INT, fetched.instr.rs2} : '0;
				// Store data and the MOV source
				OP_STORE, OP_MOV:
					rs2 = {BANK_INT, fetched.instr.rs2};
				default:
					rs2 = '0;
			endcase
		end

		// MOV of r31 names the stack pointer of the current mode
		if (rs2 == SP_AREG && fetched.instr.opcode == OP_MOV &&
			fetched.instr.funct != FUNCT_MOV_RAW)
			rs2 = SP_BANK_BASE + aregNoT'(fetched.mode);

		rs2Zero = (rs2 == '0);
	end

endmodule

`default_nettype wire

//--- decodeRs1Rd.sv
// First source and destination register decoder for the latched instruction
`timescale 1ns/1ps
`default_nettype none

module decodeRs1Rd (
	input wire decodePkg::fetchedT fetched,
	output decodePkg::aregNoT rs1,
	output decodePkg::aregNoT rd,
	output logic rdZero
);
	import isaPkg::*;
	import decodePkg::*;

	// ====================
	// Source register
	// ====================

	// Illegal opcodes and NOP read nothing
	always_comb
	begin
		if (fetched.illegal)
			rs1 = '0;
		else
		begin
			case (fetched.instr.opcode)
				OP_NOP:
					rs1 = '0;
				OP_FLT:
					rs1 = {BANK_FP, fetched.instr.rs1};
				default:
					rs1 = {BANK_INT, fetched.instr.rs1};
			endcase
		end
	end

	// ====================
	// Destination register
	// ====================

	// Stores and branches write no register
	always_comb
	begin
		if (fetched.illegal)
			rd = '0;
		else
		begin
			case (fetched.instr.opcode)
				OP_NOP, OP_STORE, OP_BCC:
					rd = '0;
				OP_FLT:
					rd = {BANK_FP, fetched.instr.rd};
				default:
					rd = {BANK_INT, fetched.instr.rd};
			endcase
		end
	end

	// Integer r0 as a target means the result is dropped
	assign rdZero = (rd == '0);

endmodule

`default_nettype wire

//--- decodeOut.sv
// Output register of the decode stage; presents one decoded record per strobe to the next stage
`timescale 1ns/1ps
`default_nettype none

module decodeOut (
	input wire logic clk,
	input wire logic rstN,
	input wire logic fetchedValid,
	input wire decodePkg::decodedT decodedIn,
	output logic outStrobe,
	output decodePkg::decodedT outDecoded
);

	// Strobe is the only control state of this stage
	always_ff @(posedge clk)
	begin
		if (!rstN)
			outStrobe <= 1'b0;
		else
			outStrobe <= fetchedValid;
	end

	// The record holds between strobes
	always_ff @(posedge clk)
	begin
		if (fetchedValid)
			outDecoded <= decodedIn;
	end

	// Every field the next stage sees on a strobe has been decoded from a real instruction
	recordKnown: assert property (@(posedge clk) disable iff (!rstN)
		outStrobe |-> !$isunknown(outDecoded))
		else $error("decodeOut: decoded record has unknown bits on outStrobe");

endmodule

`default_nettype wire

//--- decodeStage.sv
// Operand decode stage top; instruction in on inStrobe, decoded record out two cycles later
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input wire logic clk,
	input wire logic rstN,
	input wire logic inStrobe,
	input wire isaPkg::instrWordT inInstr,
	input wire decodePkg::opModeE inMode,
	output logic outStrobe,
	output decodePkg::decodedT outDecoded
);
	import isaPkg::*;
	import decodePkg::*;

	fetchedT fetched;
	logic fetchedValid;
	logic hasImm;
	logic [XLEN-1:0] imm;
	aregNoT rs1;
	aregNoT rs2;
	aregNoT rd;
	logic rdZero;
	logic rs2Zero;
	decodedT decoded;

	// ====================
	// Input side
	// ====================

	instrLatch instrLatch_i (
		.clk(clk),
		.rstN(rstN),
		.inStrobe(inStrobe),
		.inInstr(inInstr),
		.inMode(inMode),
		.fetched(fetched),
		.fetchedValid(fetchedValid)
	);

	// ====================
	// Field decoders
	// ====================

	decodeImm decodeImm_i (
		.fetched(fetched),
		.hasImm(hasImm),
		.imm(imm)
	);

	// rs2 depends on hasImm because the immediate shares its field
	decodeRs2 decodeRs2_i (
		.fetched(fetched),
		.hasImm(hasImm),
		.rs2(rs2),
		.rs2Zero(rs2Zero)
	);

	decodeRs1Rd decodeRs1Rd_i (
		.fetched(fetched),
		.rs1(rs1),
		.rd(rd),
		.rdZero(rdZero)
	);

	// Gather the decoder results into one record
	always_comb
	begin
		decoded.rd = rd;
		decoded.rs1 = rs1;
		decoded.rs2 = rs2;
		decoded.rdZero = rdZero;
		decoded.rs2Zero = rs2Zero;
		decoded.hasImm = hasImm;
		decoded.imm = imm;
		decoded.illegal = fetched.illegal;
	end

	// ====================
	// Output side
	// ====================

	decodeOut decodeOut_i (
		.clk(clk),
		.rstN(rstN),
		.fetchedValid(fetchedValid),
		.decodedIn(decoded),
		.outStrobe(outStrobe),
		.outDecoded(outDecoded)
	);

endmodule

`default_nettype wire

//--- tbDecodeStage.sv
// Self-checking testbench for the decode stage; replays decodeStim.txt and checks every record
`timescale 1ns/1ps
`default_nettype none

module tbDecodeStage;
	import isaPkg::*;
	import decodePkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int LATENCY = 2;

	logic clk = 1'b0;
	logic rstN;
	logic inStrobe;
	instrWordT inInstr;
	opModeE inMode;
	logic outStrobe;
	decodedT outDecoded;

	// Stimulus as read from the data file, one entry per line
	opModeE stimMode[$];
	instrWordT stimInstr[$];
	decodedT stimExpected[$];

	// Records in flight with the oldest at the front
	decodedT expectedQ[$];
	int sendCycleQ[$];

	int lineCount;
	int cycle = 0;
	int receivedCount = 0;
	logic stimLoaded;

	decodeStage decodeStage_i (
		.clk(clk),
		.rstN(rstN),
		.inStrobe(inStrobe),
		.inInstr(inInstr),
		.inMode(inMode),
		.outStrobe(outStrobe),
		.outDecoded(outDecoded)
	);

	always #5 clk = ~clk;

	// Cycle count used to measure the latency of each record
	always @(posedge clk)
		cycle <= cycle + 1;

	// ====================
	// Helpers
	// ====================

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
			abortRun($sformatf("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected));
	endtask

	// Reads all data lines; lines starting with # are column notes
	task automatic loadStimulus();
		int fd;
		int fieldCount;
		string lineText;
		logic [31:0] field [10];
		decodedT expected;
		fd = $fopen("decodeStim.txt", "r");
		if (fd == 0)
			abortRun("Could not open the stimulus file decodeStim.txt");
		while (!$feof(fd))
		begin
			lineText = "";
			void'($fgets(lineText, fd));
			if (lineText.len() == 0 || lineText.getc(0) == "#" || lineText.getc(0) == "\n")
				continue;
			fieldCount = $sscanf(lineText, "%h %h %h %h %h %h %h %h %h %h",
				field[0], field[1], field[2], field[3], field[4],
				field[5], field[6], field[7], field[8], field[9]);
			if (fieldCount != 10)
				abortRun($sformatf("Stimulus line has %0d fields instead of 10", fieldCount));
			expected.rd = aregNoT'(field[2]);
			expected.rs1 = aregNoT'(field[3]);
			expected.rs2 = aregNoT'(field[4]);
			expected.rdZero = field[5][0];
			expected.rs2Zero = field[6][0];
			expected.hasImm = field[7][0];
			expected.imm = field[8];
			expected.illegal = field[9][0];
			stimMode.push_back(opModeE'(field[0][1:0]));
			stimInstr.push_back(instrWordT'(field[1]));
			stimExpected.push_back(expected);
		end
		$fclose(fd);
		if (stimInstr.size() == 0)
			abortRun("The stimulus file holds no instructions");
	endtask

	// Pops the oldest record and compares every field and its latency
	task automatic compareOutput();
		decodedT expected;
		int sentCycle;
		if (expectedQ.size() == 0 || sendCycleQ.size() == 0)
			abortRun("outStrobe was asserted with no instruction outstanding");
		expected = expectedQ.pop_front();
		sentCycle = sendCycleQ.pop_front();
		receivedCount = receivedCount + 1;
		checkValue("outStrobe latency", 64'(cycle - sentCycle), 64'(LATENCY));
		checkValue("outDecoded.rd", 64'(outDecoded.rd), 64'(expected.rd));
		checkValue("outDecoded.rs1", 64'(outDecoded.rs1), 64'(expected.rs1));
		checkValue("outDecoded.rs2", 64'(outDecoded.rs2), 64'(expected.rs2));
		checkValue("outDecoded.rdZero", 64'(outDecoded.rdZero), 64'(expected.rdZero));
		checkValue("outDecoded.rs2Zero", 64'(outDecoded.rs2Zero), 64'(expected.rs2Zero));
		checkValue("outDecoded.hasImm", 64'(outDecoded.hasImm), 64'(expected.hasImm));
		checkValue("outDecoded.imm", 64'(outDecoded.imm), 64'(expected.imm));
		checkValue("outDecoded.illegal", 64'(outDecoded.illegal), 64'(expected.illegal));
	endtask

	// ====================
	// Monitor
	// ====================

	// Falling edge sampling sees both strobes settled after the rising edge
	always @(negedge clk)
	begin
		if (rstN === 1'b1 && inStrobe === 1'b1)
			sendCycleQ.push_back(cycle);
		if (outStrobe === 1'b1)
			compareOutput();
	end

	// ====================
	// Stimulus
	// ====================

	initial
	begin
		int gap;
		rstN <= 1'b0;
		inStrobe <= 1'b0;
		inInstr <= '0;
		inMode <= MODE_USER;
		stimLoaded = 1'b0;
		void'($urandom(4168));
		loadStimulus();
		lineCount = stimInstr.size();
		stimLoaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		checkValue("outStrobe", 64'(outStrobe), 64'(0));
		for (int i = 0; i < lineCount; i++)
		begin
			// Zero to two idle cycles, so some strobes come back to back
			gap = $urandom_range(2, 0);
			repeat (gap)
			begin
				@(posedge clk);
				inStrobe <= 1'b0;
			end
			@(posedge clk);
			inStrobe <= 1'b1;
			inInstr <= stimInstr[i];
			inMode <= stimMode[i];
			expectedQ.push_back(stimExpected[i]);
		end
		@(posedge clk);
		inStrobe <= 1'b0;
		while (expectedQ.size() != 0)
			@(posedge clk);
		// A few extra cycles would expose a stray output strobe
		repeat (LATENCY + 2) @(posedge clk);
		if (receivedCount == lineCount && sendCycleQ.size() == 0)
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
		else
		begin
			$display("Sent %0d instructions but received %0d records", lineCount, receivedCount);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	end

	// Each line needs at most three cycles plus reset and pipeline drain
	initial
	begin
		wait (stimLoaded === 1'b1);
		repeat (lineCount * 4 + 50) @(posedge clk);
		abortRun($sformatf("Timeout, the run did not finish within %0d cycles",
			lineCount * 4 + 50));
	end

endmodule

`default_nettype wire

//--- decodeStim.txt
# mode instr rd rs1 rs2 rdZero rs2Zero hasImm imm illegal, all in hex
# mode 0 user, 1 super, 2 hyper, 3 machine
0 00041181 03 01 02 0 0 0 00000000 0
1 000E6282 05 06 07 0 0 0 00000000 0
2 00124007 00 04 09 1 0 0 00000000 0
3 003BEF85 1F 1E 1D 0 0 0 00000000 0
0 00148611 00 08 0A 1 0 0 00000000 0
0 00C02086 01 02 00 0 1 0 00000000 0
0 82461101 02 01 00 0 1 1 00000123 0
1 FFE03210 04 03 00 0 1 1 FFFFFFF0 0
2 C0005011 00 05 00 1 1 1 FFFFE000 0
3 BFFE03C0 07 00 00 0 1 1 00001FFF 0
0 80043230 24 23 22 0 0 0 00000000 0
0 800C1138 02 01 06 0 0 0 00000000 0
0 8092A1A0 00 0A 09 1 0 0 00000000 0
1 00CC1138 02 01 00 0 1 0 00000000 0
1 0016C6B8 0D 0C 0B 0 0 0 00000000 0
2 01D24020 00 04 00 1 1 0 00000000 0
2 000222A0 00 02 01 1 0 0 00000000 0
3 005CF810 10 0F 0E 0 0 0 00000000 0
3 001CF810 10 0F 00 0 1 0 00000000 0
0 003E0030 20 20 3F 0 0 0 00000000 0
0 003E1140 02 01 40 0 0 0 00000000 0
1 003E1140 02 01 41 0 0 0 00000000 0
2 003E1140 02 01 42 0 0 0 00000000 0
3 003E1140 02 01 43 0 0 0 00000000 0
2 007E1140 02 01 1F 0 0 0 00000000 0
3 017C1140 02 01 1E 0 0 0 00000000 0
1 00BE1140 02 01 41 0 0 0 00000000 0
0 00064280 00 00 00 1 1 0 00000000 0
3 800642FF 00 00 00 1 1 0 00000000 1
1 00064288 00 00 00 1 1 0 00000000 1
2 003E1141 00 00 00 1 1 0 00000000 1
0 00000001 00 00 00 1 1 0 00000000 0

//--- verilog.f
isaPkg.sv
decodePkg.sv
instrLatch.sv
decodeImm.sv
decodeRs2.sv
decodeRs1Rd.sv
decodeOut.sv
decodeStage.sv
tbDecodeStage.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tbDecodeStage \
	-o tbDecodeStage > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tbDecodeStage > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
	|| { grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation ended early"; exit 1; }; }
